//--- alu_pkg.sv
package alu_pkg;

    // --------------------------------------------------
    // ALU operation select
    // --------------------------------------------------
    typedef enum logic [3:0] {
        alu_add  = 4'd0,     // Sum through shared adder
        alu_sub  = 4'd1,     // Difference, same adder
        alu_slt  = 4'd2,     // Signed less-than
        alu_sltu = 4'd3,     // Unsigned less-than
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_xor  = 4'd6,
        alu_sll  = 4'd7,     // Shift left logical
        alu_srl  = 4'd8,     // Shift right, zero fill
        alu_sra  = 4'd9      // Shift right, sign fill
    } alu_op_e;

    // --------------------------------------------------
    // RV32I major opcodes, only the two we execute
    // --------------------------------------------------
    localparam logic [6:0] opc_op     = 7'b0110011;    // Register-register
    localparam logic [6:0] opc_op_imm = 7'b0010011;    // Register-immediate

    // --------------------------------------------------
    // funct3 codes shared by OP and OP-IMM
    // --------------------------------------------------
    localparam logic [2:0] f3_add  = 3'b000;    // ADD / SUB / ADDI
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;    // SRL and SRA, split by bit 30
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

endpackage

//--- alu_adder.sv
module alu_adder #(
    parameter int BW = 32
) (
    input  logic            choose_add_sub,    // 1 selects subtract
    input  logic [BW-1:0]   add_1,
    input  logic [BW-1:0]   add_2,
    input  logic [BW-1:0]   add_2_inv,         // Inverted copy of add_2
    output logic [BW-1:0]   result
);

    logic [BW-1:0] operand_b;    // Second addend after mode select
    logic [BW-1:0] carry_in;     // Mode bit widened to BW

    // --------------------------------------------------
    // Operand select
    // --------------------------------------------------
    // Subtract is a + ~b + 1, so the mode bit doubles as carry-in
    always_comb begin
        if (choose_add_sub) begin
            operand_b = add_2_inv;
        end else begin
            operand_b = add_2;
        end
    end

    assign carry_in = {{(BW-1){1'b0}}, choose_add_sub};

    // --------------------------------------------------
    // Single carry chain
    // --------------------------------------------------
    assign result = add_1 + operand_b + carry_in;    // Carry-out dropped

endmodule

//--- alu.sv
module alu #(
    parameter int BW = 32
) (
    input  logic [BW-1:0]       d1,
    input  logic [BW-1:0]       d2,
    input  alu_pkg::alu_op_e    op,
    output logic [BW-1:0]       res
);

    localparam int SHW = $clog2(BW);    // Shift amount width

    logic            choose_add_sub;    // Adder mode, 1 means d1 - d2
    logic [BW-1:0]   add_res;           // Shared adder output
    logic [BW-1:0]   d1_inv;
    logic [BW-1:0]   d2_inv;
    logic [SHW-1:0]  shamt;             // Low bits of d2 only
    logic            lt_signed;
    logic            lt_unsigned;

    assign d1_inv = ~d1;
    assign d2_inv = ~d2;
    assign shamt  = d2[SHW-1:0];

    // --------------------------------------------------
    // Adder mode
    // --------------------------------------------------
    always_comb begin
        case (op)
            alu_pkg::alu_sub,
            alu_pkg::alu_slt: choose_add_sub = 1'b1;    // Need difference
            default:          choose_add_sub = 1'b0;
        endcase
    end

    alu_adder #(
        .BW             (BW)
    ) i_alu_adder (
        .choose_add_sub (choose_add_sub),
        .add_1          (d1),
        .add_2          (d2),
        .add_2_inv      (d2_inv),
        .result         (add_res)
    );

    // --------------------------------------------------
    // Compares
    // --------------------------------------------------
    // Signs differ: negative one is smaller, no overflow worry
    // Signs equal: difference cannot overflow, its sign decides
    always_comb begin
        if (d1[BW-1] != d2[BW-1]) begin
            lt_signed = d1[BW-1];
        end else begin
            lt_signed = add_res[BW-1];
        end
    end

    assign lt_unsigned = (d1 < d2);

    // --------------------------------------------------
    // Result select
    // --------------------------------------------------
    always_comb begin
        res = '0;    // Unlisted op codes give zero
        case (op)
            alu_pkg::alu_add,
            alu_pkg::alu_sub:  res = add_res;
            alu_pkg::alu_slt:  res = {{(BW-1){1'b0}}, lt_signed};
            alu_pkg::alu_sltu: res = {{(BW-1){1'b0}}, lt_unsigned};
            alu_pkg::alu_and:  res = d1 & d2;
            alu_pkg::alu_or:   res = d1 | d2;
            alu_pkg::alu_xor:  res = (d1 & d2_inv) | (d1_inv & d2);    // Sum of products
            alu_pkg::alu_sll:  res = d1 << shamt;
            alu_pkg::alu_srl:  res = d1 >> shamt;                      // Zero fill
            alu_pkg::alu_sra:  res = $signed(d1) >>> shamt;           // Sign fill
            default:           res = '0;
        endcase
    end

endmodule

//--- alu_decoder.sv
module alu_decoder (
    input  logic [31:0]         inst,
    output logic [4:0]          rs1,
    output logic [4:0]          rs2,
    output logic [4:0]          rd,
    output logic [31:0]         imm,
    output logic                use_imm,       // Second operand from imm
    output alu_pkg::alu_op_e    alu_op,
    output logic                rd_we,
    output logic                is_illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_zero;    // funct7 all zero
    logic       f7_alt;     // funct7 is 0100000, SUB / SRA form
    logic       legal;

    // --------------------------------------------------
    // Field extraction
    // --------------------------------------------------
    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    assign imm     = {{20{inst[31]}}, inst[31:20]};    // I-type, sign extended
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);
    assign use_imm = (opcode == alu_pkg::opc_op_imm);

    // --------------------------------------------------
    // Operation and legality
    // --------------------------------------------------
    always_comb begin
        alu_op = alu_pkg::alu_add;
        legal  = 1'b0;
        // Base mapping from funct3, bit 30 splits add/sub and srl/sra
        case (funct3)
            alu_pkg::f3_add:  alu_op = alu_pkg::alu_add;
            alu_pkg::f3_sll:  alu_op = alu_pkg::alu_sll;
            alu_pkg::f3_slt:  alu_op = alu_pkg::alu_slt;
            alu_pkg::f3_sltu: alu_op = alu_pkg::alu_sltu;
            alu_pkg::f3_xor:  alu_op = alu_pkg::alu_xor;
            alu_pkg::f3_sr:   alu_op = inst[30] ? alu_pkg::alu_sra : alu_pkg::alu_srl;
            alu_pkg::f3_or:   alu_op = alu_pkg::alu_or;
            alu_pkg::f3_and:  alu_op = alu_pkg::alu_and;
            default:          alu_op = alu_pkg::alu_add;
        endcase
        if (opcode == alu_pkg::opc_op) begin
            if (funct3 == alu_pkg::f3_add) begin
                legal = f7_zero | f7_alt;                      // ADD or SUB
                if (f7_alt) alu_op = alu_pkg::alu_sub;
            end else if (funct3 == alu_pkg::f3_sr) begin
                legal = f7_zero | f7_alt;                      // SRL or SRA
            end else begin
                legal = f7_zero;
            end
        end else if (opcode == alu_pkg::opc_op_imm) begin
            if (funct3 == alu_pkg::f3_sll) begin
                legal = f7_zero;                               // SLLI has no alt form
            end else if (funct3 == alu_pkg::f3_sr) begin
                legal = f7_zero | f7_alt;                      // SRLI or SRAI
            end else begin
                legal = 1'b1;    // Upper bits are immediate, ADDI ignores bit 30
            end
        end
    end

    assign is_illegal = ~legal;
    assign rd_we      = legal;

endmodule

//--- reg_file.sv
module reg_file (
    input  logic        clock,
    input  logic        rst_n,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [1:31];    // x0 has no storage

    // --------------------------------------------------
    // Write port
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;                   // All registers start at zero
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;               // Writes to x0 dropped
        end
    end

    // --------------------------------------------------
    // Read ports
    // --------------------------------------------------
    // Combinational, so a read sees the value once the edge has passed
    always_comb begin
        if (raddr1 == 5'd0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
        if (raddr2 == 5'd0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

//--- alu_exec_top.sv
module alu_exec_top (
    input  logic        clock,
    input  logic        rst_n,
    input  logic        inst_valid,    // One-cycle strobe, no back-pressure
    input  logic [31:0] inst,
    output logic        wb_valid,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data,
    output logic        illegal
);

    localparam int XLEN = 32;    // Data path width handed to the ALU

    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic [4:0]         rd;
    logic [31:0]        imm;
    logic               use_imm;
    alu_pkg::alu_op_e   alu_op;
    logic               rd_we;
    logic               is_illegal;
    logic [31:0]        rs1_data;
    logic [31:0]        rs2_data;
    logic [XLEN-1:0]    alu_d2;      // Second operand after select
    logic [XLEN-1:0]    res;
    logic               rf_we;

    // --------------------------------------------------
    // Decode, read, execute
    // --------------------------------------------------
    alu_decoder i_alu_decoder (
        .inst       (inst),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .imm        (imm),
        .use_imm    (use_imm),
        .alu_op     (alu_op),
        .rd_we      (rd_we),
        .is_illegal (is_illegal)
    );

    reg_file i_reg_file (
        .clock  (clock),
        .rst_n  (rst_n),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data),
        .we     (rf_we),
        .waddr  (rd),
        .wdata  (res)
    );

    assign alu_d2 = use_imm ? imm : rs2_data;          // OP-IMM takes immediate
    assign rf_we  = inst_valid & rd_we & (rd != 5'd0);

    alu #(
        .BW (XLEN)
    ) i_alu (
        .d1  (rs1_data),
        .d2  (alu_d2),
        .op  (alu_op),
        .res (res)
    );

    // --------------------------------------------------
    // Write-back register
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            illegal  <= 1'b0;
            wb_rd    <= '0;
            wb_data  <= '0;
        end else begin
            wb_valid <= inst_valid & ~is_illegal;      // Strobe, one cycle
            illegal  <= inst_valid & is_illegal;
            if (inst_valid && !is_illegal) begin
                wb_rd   <= rd;                         // x0 still reported
                wb_data <= res;
            end
        end
    end

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
    parameter int HALF_PERIOD = 5    // Full period 10
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
    end

    always #HALF_PERIOD clock = ~clock;    // Free running

endmodule

//--- tb_alu_exec.sv
module tb_alu_exec;

    localparam logic [31:0] lcg_seed  = 32'h56df_36b4;
    localparam int          n_rand    = 200;                  // Per random phase
    localparam int          n_inst    = 2 * n_rand + 64;      // Random plus directed and idle
    localparam int          rst_time  = 8 * 10;
    localparam int          wd_time   = n_inst * 10 * 2 + rst_time;
    localparam logic [6:0]  opc_reg   = 7'b0110011;
    localparam logic [6:0]  opc_imm   = 7'b0010011;
    localparam logic [6:0]  opc_load  = 7'b0000011;           // Not executed here

    logic        clock;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        illegal;

    logic [31:0] rand_state;
    logic [31:0] model_regs [0:31];    // Reference register array
    logic        exp_valid_d;          // Set at drive time
    logic        exp_illegal_d;
    logic [4:0]  exp_rd_d;
    logic [31:0] exp_data_d;
    logic        exp_valid_q;          // Aligned with DUT outputs
    logic        exp_illegal_q;
    logic [4:0]  exp_rd_q;
    logic [31:0] exp_data_q;

    tb_clock_gen i_tb_clock_gen (.clock(clock));

    alu_exec_top i_alu_exec_top (
        .clock      (clock),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .illegal    (illegal)
    );

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_reg};
    endfunction

    function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, opc_imm};
    endfunction

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    // Reference model from RV32I rules, then drive on the falling edge
    task automatic issue(input logic [31:0] word);
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic        ok;
        opc = word[6:0];
        f3  = word[14:12];
        f7  = word[31:25];
        a   = model_regs[word[19:15]];    // Entry 0 never written
        b   = (opc == opc_imm) ? {{20{word[31]}}, word[31:20]} : model_regs[word[24:20]];
        ok  = 1'b0;
        if (opc == opc_reg) begin
            ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        end else if (opc == opc_imm) begin
            ok = (f3 == 3'd1) ? (f7 == 7'h00) :
                 (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
        end
        case (f3)
            3'd0: val = (opc == opc_reg && f7[5]) ? a - b : a + b;    // SUB only in OP
            3'd1: val = a << b[4:0];
            3'd2: val = {31'd0, $signed(a) < $signed(b)};
            3'd3: val = {31'd0, a < b};
            3'd4: val = a ^ b;
            3'd5: begin
                if (f7[5]) begin
                    val = $signed(a) >>> b[4:0];    // Sign fill
                end else begin
                    val = a >> b[4:0];
                end
            end
            3'd6: val = a | b;
            default: val = a & b;
        endcase
        @(negedge clock);
        inst          = word;
        inst_valid    = 1'b1;
        exp_valid_d   = ok;
        exp_illegal_d = !ok;
        exp_rd_d      = word[11:7];
        exp_data_d    = val;
        if (ok && word[11:7] != 5'd0) model_regs[word[11:7]] = val;
    endtask

    task automatic idle();
        @(negedge clock);
        inst_valid    = 1'b0;
        inst          = next_rand();    // Ignored without strobe
        exp_valid_d   = 1'b0;
        exp_illegal_d = 1'b0;
    endtask

    always @(posedge clock) begin
        exp_valid_q   <= exp_valid_d;      // One cycle latency
        exp_illegal_q <= exp_illegal_d;
        exp_rd_q      <= exp_rd_d;
        exp_data_q    <= exp_data_d;
    end

    // --------------------------------------------------
    // Checks sampled mid-cycle
    // --------------------------------------------------
    a_wb_valid: assert property (@(negedge clock) rst_n |-> wb_valid == exp_valid_q)
        else report_fail(exp_valid_q ? "Write-back strobe missing"
                                     : "Unexpected write-back strobe");
    a_illegal: assert property (@(negedge clock) rst_n |-> illegal == exp_illegal_q)
        else report_fail(exp_illegal_q ? "Illegal strobe missing" : "Unexpected illegal strobe");
    a_wb_rd: assert property (@(negedge clock) rst_n && exp_valid_q |-> wb_rd == exp_rd_q)
        else report_fail($sformatf("MISMATCH time %0t wb_rd expected %0d actual %0d",
                                   $time, exp_rd_q, wb_rd));
    a_wb_data: assert property (@(negedge clock) rst_n && exp_valid_q |-> wb_data == exp_data_q)
        else report_fail($sformatf("MISMATCH time %0t wb_data expected %h actual %h",
                                   $time, exp_data_q, wb_data));

    initial begin
        #(wd_time);
        report_fail("Watchdog timeout, stimulus did not finish");
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        logic [31:0] r;
        logic [2:0]  f3;
        logic [11:0] imm;
        rst_n = 1'b0;
        inst_valid = 1'b0;
        inst = '0;
        rand_state = lcg_seed;
        exp_valid_d = 1'b0;
        exp_illegal_d = 1'b0;
        exp_rd_d = '0;
        exp_data_d = '0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        repeat (8) @(posedge clock);
        @(negedge clock) rst_n = 1'b1;
        repeat (3) idle();                                   // No strobes yet
        issue(r_format(7'h00, 5'd9, 5'd7, 3'd0, 5'd5));      // Reads of reset regs
        issue(i_format(12'd5, 5'd31, 3'd0, 5'd6));
        // Sign boundary operands and shift amounts
        issue(i_format(12'd1, 5'd0, 3'd0, 5'd1));
        issue(i_format({7'h00, 5'd31}, 5'd1, 3'd1, 5'd1));   // x1 = 8000_0000
        issue(i_format(12'hfff, 5'd0, 3'd0, 5'd2));
        issue(i_format({7'h00, 5'd1}, 5'd2, 3'd5, 5'd2));    // x2 = 7fff_ffff
        issue(i_format(12'hfff, 5'd0, 3'd0, 5'd3));
        issue(i_format(12'd31, 5'd0, 3'd0, 5'd4));
        issue(r_format(7'h00, 5'd2, 5'd1, 3'd2, 5'd8));
        issue(r_format(7'h00, 5'd2, 5'd1, 3'd3, 5'd8));
        issue(r_format(7'h00, 5'd1, 5'd2, 3'd2, 5'd8));
        issue(r_format(7'h00, 5'd1, 5'd3, 3'd3, 5'd9));
        issue(r_format(7'h00, 5'd0, 5'd3, 3'd2, 5'd9));
        issue(r_format(7'h20, 5'd4, 5'd1, 3'd5, 5'd6));      // SRA by 31
        issue(r_format(7'h00, 5'd4, 5'd1, 3'd5, 5'd6));
        issue(r_format(7'h00, 5'd4, 5'd3, 3'd1, 5'd6));
        issue(r_format(7'h00, 5'd0, 5'd2, 3'd1, 5'd7));      // Shift by 0
        issue(r_format(7'h20, 5'd3, 5'd1, 3'd0, 5'd7));
        issue(i_format({7'h20, 5'd31}, 5'd1, 3'd5, 5'd6));   // SRAI
        for (int i = 0; i < n_rand; i++) begin               // Random R-type
            r  = next_rand();
            f3 = r[14:12];
            issue(r_format(((f3 == 3'd0 || f3 == 3'd5) && r[30]) ? 7'h20 : 7'h00,
                           r[24:20], r[19:15], f3, r[11:7]));
        end
        for (int i = 0; i < n_rand; i++) begin               // Random I-type
            r   = next_rand();
            f3  = r[14:12];
            imm = r[31:20];
            if (f3 == 3'd1) imm[11:5] = 7'h00;
            else if (f3 == 3'd5) imm[11:5] = r[5] ? 7'h20 : 7'h00;
            issue(i_format(imm, r[19:15], f3, r[11:7]));
        end
        issue(i_format(12'd100, 5'd0, 3'd0, 5'd10));         // Dependent chain
        for (int i = 0; i < 8; i++) issue(i_format(12'd7 + i[11:0], 5'd10, 3'd0, 5'd10));
        issue(i_format(12'd123, 5'd10, 3'd0, 5'd0));         // Write to x0
        issue(r_format(7'h00, 5'd0, 5'd0, 3'd0, 5'd11));
        issue(i_format(12'd77, 5'd0, 3'd0, 5'd12));
        issue({12'd4, 5'd1, 3'b010, 5'd12, opc_load});       // Load opcode
        issue(r_format(7'h01, 5'd2, 5'd1, 3'd0, 5'd12));     // Bad funct7
        issue(i_format({7'h20, 5'd3}, 5'd1, 3'd1, 5'd12));   // SLLI with bit 30
        issue(i_format(12'd0, 5'd12, 3'd0, 5'd13));          // x12 still 77
        repeat (3) idle();
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- verilog.f
alu_pkg.sv
alu_adder.sv
alu.sv
alu_decoder.sv
reg_file.sv
alu_exec_top.sv
tb_clock_gen.sv
tb_alu_exec.sv
